// File: all.f
hdl/apb_soc_pkg.sv
hdl/periph_pkg.sv
hdl/apb_periph_bus.sv
hdl/apb_gpio.sv
hdl/apb_pwm_timer.sv
hdl/apb_subsystem.sv
verification/tb_apb_subsystem.sv

// File: run.sh
#!/bin/sh
# Builds the APB subsystem testbench with Verilator and runs it.
# The exit status is the simulation's own status.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
   -f all.f --top-module tb_apb_subsystem \
   -Mdir obj_dir -o tb_apb_subsystem
build_status=$?
if [ $build_status -ne 0 ]; then
   echo "Verilator build failed with status $build_status"
   exit $build_status
fi

./obj_dir/tb_apb_subsystem
sim_status=$?
if [ $sim_status -ne 0 ]; then
   echo "Simulation failed with status $sim_status"
fi
exit $sim_status

// File: verification/tb_apb_subsystem.sv
/*
 * Testbench for the APB subsystem with 16 GPIO pins and 4 PWM channels.
 * Inputs change 1 ns after the rising edge. Registered outputs are
 * sampled there and bus responses at the falling edge of the access cycle.
 * Data comes from a 32-bit Galois LFSR with a fixed seed.
 */

`timescale 1ns/1ps

module tb_apb_subsystem;

   localparam int unsigned AW       = apb_soc_pkg::APB_ADDR_WIDTH;
   localparam int unsigned DW       = apb_soc_pkg::APB_DATA_WIDTH;
   localparam int unsigned WB       = apb_soc_pkg::PERIPH_WIN_BITS;
   localparam int unsigned NUM_GPIO = 16;
   localparam int unsigned NUM_PWM  = 4;
   // The whole run takes well under a thousand cycles
   localparam int unsigned MAX_CYCLES = 3000;
   localparam logic [AW-1:0] UNMAPPED_ADDR = 32'h0000_2000;
   localparam logic [DW-1:0] GPIO_MASK = 32'((64'd1 << NUM_GPIO) - 64'd1);

   logic                clk_i;
   logic                rst_n_i;
   logic [AW-1:0]       paddr_i;
   logic [DW-1:0]       pwdata_i;
   logic                pwrite_i;
   logic                psel_i;
   logic                penable_i;
   logic [DW-1:0]       prdata_o;
   logic                pready_o;
   logic                pslverr_o;
   logic [NUM_GPIO-1:0] gpio_in_i;
   logic [NUM_GPIO-1:0] gpio_out_o;
   logic [NUM_GPIO-1:0] gpio_oe_o;
   logic [NUM_PWM-1:0]  pwm_o;
   logic [1:0]          events_o;

   logic [31:0]   lfsr_q = 32'habea_55ff;
   int unsigned   cycles = 0;
   logic          last_err;
   logic [31:0]   period_v;
   logic [31:0]   duty_v [NUM_PWM];

   apb_subsystem #(
      .NUM_GPIO ( NUM_GPIO ),
      .NUM_PWM  ( NUM_PWM  )
   ) u_apb_subsystem (
      .clk_i      ( clk_i      ),
      .rst_n_i    ( rst_n_i    ),
      .paddr_i    ( paddr_i    ),
      .pwdata_i   ( pwdata_i   ),
      .pwrite_i   ( pwrite_i   ),
      .psel_i     ( psel_i     ),
      .penable_i  ( penable_i  ),
      .prdata_o   ( prdata_o   ),
      .pready_o   ( pready_o   ),
      .pslverr_o  ( pslverr_o  ),
      .gpio_in_i  ( gpio_in_i  ),
      .gpio_out_o ( gpio_out_o ),
      .gpio_oe_o  ( gpio_oe_o  ),
      .pwm_o      ( pwm_o      ),
      .events_o   ( events_o   )
   );

   initial begin
      clk_i = 1'b0;
      forever #5 clk_i = ~clk_i;
   end

   always @(posedge clk_i) begin
      cycles <= cycles + 1;
      if (cycles >= MAX_CYCLES) begin
         $display("Timeout: the test did not finish within %0d cycles", MAX_CYCLES);
         $display("TEST FAILED");
         $fatal(1, "timeout");
      end
   end

   task automatic stop_on_error(input string msg);
      $display("** Error at %0t ns: %s", $time, msg);
      $display("TEST FAILED");
      $fatal(1, "check failed");
   endtask

   // One LFSR step per bit taken
   function automatic logic [31:0] rand_bits(input int n);
      logic [31:0] r;
      r = '0;
      for (int i = 0; i < n; i++) begin
         r = {r[30:0], lfsr_q[0]};
         lfsr_q = lfsr_q[0] ? ((lfsr_q >> 1) ^ 32'h8020_0003) : (lfsr_q >> 1);
      end
      return r;
   endfunction

   function automatic logic is_mapped(input logic [AW-1:0] addr);
      return (addr[AW-1:WB] == apb_soc_pkg::GPIO_BASE[AW-1:WB]) ||
             (addr[AW-1:WB] == apb_soc_pkg::PWM_BASE[AW-1:WB]);
   endfunction

   function automatic logic [AW-1:0] gpio_addr(input logic [WB-1:0] ofs);
      return apb_soc_pkg::GPIO_BASE | {{(AW-WB){1'b0}}, ofs};
   endfunction

   function automatic logic [AW-1:0] pwm_addr(input logic [WB-1:0] ofs);
      return apb_soc_pkg::PWM_BASE | {{(AW-WB){1'b0}}, ofs};
   endfunction

   a_ready_in_access: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      pready_o == (psel_i && penable_i))
      else stop_on_error("pready_o does not match the APB access cycle");

   a_err_unmapped: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      pslverr_o == (psel_i && penable_i && !is_mapped(paddr_i)))
      else stop_on_error("pslverr_o does not match the address map");

   task automatic next_cycle();
      @(posedge clk_i);
      #1;
   endtask

   task automatic check_idle_outputs(input string when_s);
      assert (!pready_o && !pslverr_o && gpio_oe_o == '0 && gpio_out_o == '0 &&
              pwm_o == '0 && events_o == '0)
         else stop_on_error({"outputs are not inactive ", when_s});
   endtask

   // Setup cycle, then access cycle; returns one cycle after the access
   task automatic apb_xfer(input logic wr, input logic [AW-1:0] addr,
                           input logic [DW-1:0] wdata, output logic [DW-1:0] rdata);
      paddr_i   = addr;
      pwdata_i  = wdata;
      pwrite_i  = wr;
      psel_i    = 1'b1;
      penable_i = 1'b0;
      next_cycle();
      penable_i = 1'b1;
      @(negedge clk_i);
      assert (pready_o) else stop_on_error("pready_o low in the access cycle");
      rdata    = prdata_o;
      last_err = pslverr_o;
      next_cycle();
      psel_i    = 1'b0;
      penable_i = 1'b0;
      pwrite_i  = 1'b0;
   endtask

   task automatic apb_write(input logic [AW-1:0] addr, input logic [DW-1:0] data);
      logic [DW-1:0] unused_rdata;
      apb_xfer(1'b1, addr, data, unused_rdata);
   endtask

   task automatic apb_read(input logic [AW-1:0] addr, output logic [DW-1:0] data);
      apb_xfer(1'b0, addr, '0, data);
   endtask

   task automatic check_read(input logic [AW-1:0] addr, input logic [DW-1:0] exp,
                             input string what);
      logic [DW-1:0] data;
      apb_read(addr, data);
      assert (data === exp && !last_err)
         else stop_on_error($sformatf("%s read 0x%08h, expected 0x%08h", what, data, exp));
   endtask

   // Counts high cycles and period events over one period from now
   task automatic check_pwm_window();
      logic [31:0] high_cnt [NUM_PWM];
      logic [31:0] evt_cnt;
      evt_cnt = '0;
      for (int ch = 0; ch < NUM_PWM; ch++)
         high_cnt[ch] = '0;
      repeat (period_v) begin
         for (int ch = 0; ch < NUM_PWM; ch++)
            high_cnt[ch] = high_cnt[ch] + 32'(pwm_o[ch]);
         evt_cnt = evt_cnt + 32'(events_o[1]);
         next_cycle();
      end
      assert (evt_cnt == 32'd1)
         else stop_on_error($sformatf("%0d PWM events in one period", evt_cnt));
      for (int ch = 0; ch < NUM_PWM; ch++)
         assert (high_cnt[ch] == duty_v[ch])
            else stop_on_error($sformatf("PWM channel %0d high %0d cycles, expected %0d",
                                         ch, high_cnt[ch], duty_v[ch]));
   endtask

   initial begin
      logic [31:0] dir_v;
      logic [31:0] out_v;
      logic [31:0] in_v;
      logic [31:0] prev_in;
      logic [31:0] mask_v;
      logic [31:0] sts_v;
      logic [31:0] rdata;
      rst_n_i   = 1'b0;
      paddr_i   = '0;
      pwdata_i  = '0;
      pwrite_i  = 1'b0;
      psel_i    = 1'b0;
      penable_i = 1'b0;
      gpio_in_i = '0;
      repeat (5) begin
         next_cycle();
         check_idle_outputs("during reset");
      end
      rst_n_i = 1'b1;
      next_cycle();
      check_idle_outputs("after reset");

      // GPIO direction and output registers
      repeat (4) begin
         dir_v = rand_bits(32);
         out_v = rand_bits(32);
         apb_write(gpio_addr(periph_pkg::GPIO_DIR_OFS), dir_v);
         assert (gpio_oe_o == dir_v[NUM_GPIO-1:0])
            else stop_on_error("gpio_oe_o differs from the written DIR value");
         apb_write(gpio_addr(periph_pkg::GPIO_OUT_OFS), out_v);
         assert (gpio_out_o == out_v[NUM_GPIO-1:0] && gpio_oe_o == dir_v[NUM_GPIO-1:0])
            else stop_on_error("gpio_out_o differs from the written OUT value");
         check_read(gpio_addr(periph_pkg::GPIO_DIR_OFS), dir_v & GPIO_MASK, "DIR");
         check_read(gpio_addr(periph_pkg::GPIO_OUT_OFS), out_v & GPIO_MASK, "OUT");
      end

      // GPIO inputs, rising edge status and interrupt
      mask_v = rand_bits(NUM_GPIO);
      apb_write(gpio_addr(periph_pkg::GPIO_IRQ_EN_OFS), mask_v);
      prev_in = '0;
      repeat (8) begin
         in_v      = rand_bits(NUM_GPIO);
         gpio_in_i = in_v[NUM_GPIO-1:0];
         sts_v     = in_v & ~prev_in;
         prev_in   = in_v;
         repeat (4) next_cycle();
         check_read(gpio_addr(periph_pkg::GPIO_IN_OFS), in_v, "IN");
         check_read(gpio_addr(periph_pkg::GPIO_IRQ_STS_OFS), sts_v, "IRQ status");
         assert (events_o[0] == |(sts_v & mask_v))
            else stop_on_error("GPIO event does not follow status and mask");
         apb_write(gpio_addr(periph_pkg::GPIO_IRQ_STS_OFS), sts_v);
         assert (!events_o[0]) else stop_on_error("GPIO event still high after clear");
         check_read(gpio_addr(periph_pkg::GPIO_IRQ_STS_OFS), '0, "cleared IRQ status");
      end

      // PWM with random period and duties below it
      period_v = 32'd8 + rand_bits(5);
      for (int ch = 0; ch < NUM_PWM; ch++) begin
         duty_v[ch] = rand_bits(6) % period_v;
         apb_write(pwm_addr(periph_pkg::PWM_DUTY_OFS + 12'(4 * ch)), duty_v[ch]);
      end
      apb_write(pwm_addr(periph_pkg::PWM_PERIOD_OFS), period_v);
      check_read(pwm_addr(periph_pkg::PWM_PERIOD_OFS), period_v, "PWM period");
      apb_write(pwm_addr(periph_pkg::PWM_CTRL_OFS), 32'd1);
      while (!events_o[1])
         next_cycle();
      check_pwm_window();
      repeat (1 + rand_bits(3)) next_cycle();
      check_pwm_window();
      apb_write(pwm_addr(periph_pkg::PWM_CTRL_OFS), 32'd0);
      next_cycle();
      repeat (period_v) begin
         assert (pwm_o == '0 && !events_o[1])
            else stop_on_error("PWM still active after the timer was disabled");
         next_cycle();
      end

      // Unmapped window
      apb_write(UNMAPPED_ADDR, rand_bits(32));
      assert (last_err) else stop_on_error("no pslverr_o on an unmapped write");
      apb_read(UNMAPPED_ADDR, rdata);
      assert (last_err && rdata == '0)
         else stop_on_error($sformatf("unmapped read gave 0x%08h err %0b", rdata, last_err));
      check_read(gpio_addr(periph_pkg::GPIO_DIR_OFS), dir_v & GPIO_MASK, "DIR");
      check_read(gpio_addr(periph_pkg::GPIO_OUT_OFS), out_v & GPIO_MASK, "OUT");
      check_read(pwm_addr(periph_pkg::PWM_CTRL_OFS), '0, "PWM control");
      check_read(pwm_addr(periph_pkg::PWM_PERIOD_OFS), period_v, "PWM period");
      check_read(pwm_addr(periph_pkg::PWM_DUTY_OFS), duty_v[0], "PWM duty 0");

      $display("TEST OK");
      $finish;
   end

endmodule

// File: hdl/apb_subsystem.sv
/*
 * APB peripheral subsystem with a GPIO block and a PWM timer.
 * Single clock, no wait states. events_o bit 0 is the GPIO interrupt
 * level and bit 1 the PWM period pulse.
 */

`timescale 1ns/1ps

module apb_subsystem #(
   parameter int unsigned NUM_GPIO = 16,
   parameter int unsigned NUM_PWM  = 4
) (
   input  logic                                   clk_i,
   input  logic                                   rst_n_i,
   input  logic [apb_soc_pkg::APB_ADDR_WIDTH-1:0] paddr_i,
   input  logic [apb_soc_pkg::APB_DATA_WIDTH-1:0] pwdata_i,
   input  logic                                   pwrite_i,
   input  logic                                   psel_i,
   input  logic                                   penable_i,
   output logic [apb_soc_pkg::APB_DATA_WIDTH-1:0] prdata_o,
   output logic                                   pready_o,
   output logic                                   pslverr_o,
   input  logic [NUM_GPIO-1:0]                    gpio_in_i,
   output logic [NUM_GPIO-1:0]                    gpio_out_o,
   output logic [NUM_GPIO-1:0]                    gpio_oe_o,
   output logic [NUM_PWM-1:0]                     pwm_o,
   output logic [1:0]                             events_o
);

   logic [apb_soc_pkg::PERIPH_WIN_BITS-1:0]  s_paddr;
   logic [apb_soc_pkg::APB_DATA_WIDTH-1:0]   s_pwdata;
   logic                                     s_pwrite;
   logic                                     s_penable;
   logic                                     s_gpio_psel;
   logic [apb_soc_pkg::APB_DATA_WIDTH-1:0]   s_gpio_prdata;
   logic                                     s_gpio_pready;
   logic                                     s_pwm_psel;
   logic [apb_soc_pkg::APB_DATA_WIDTH-1:0]   s_pwm_prdata;
   logic                                     s_pwm_pready;
   logic                                     s_gpio_irq;
   logic                                     s_pwm_evt;

   assign events_o = {s_pwm_evt, s_gpio_irq};

   apb_periph_bus i_apb_periph_bus (
      .clk_i            ( clk_i         ),
      .rst_n_i          ( rst_n_i       ),
      .paddr_i          ( paddr_i       ),
      .pwrite_i         ( pwrite_i      ),
      .psel_i           ( psel_i        ),
      .penable_i        ( penable_i     ),
      .pwdata_i         ( pwdata_i      ),
      .prdata_o         ( prdata_o      ),
      .pready_o         ( pready_o      ),
      .pslverr_o        ( pslverr_o     ),
      .gpio_psel_o      ( s_gpio_psel   ),
      .gpio_prdata_i    ( s_gpio_prdata ),
      .gpio_pready_i    ( s_gpio_pready ),
      .pwm_psel_o       ( s_pwm_psel    ),
      .pwm_prdata_i     ( s_pwm_prdata  ),
      .pwm_pready_i     ( s_pwm_pready  ),
      .periph_paddr_o   ( s_paddr       ),
      .periph_pwdata_o  ( s_pwdata      ),
      .periph_pwrite_o  ( s_pwrite      ),
      .periph_penable_o ( s_penable     )
   );

   apb_gpio #(
      .NUM_GPIO ( NUM_GPIO )
   ) i_apb_gpio (
      .clk_i      ( clk_i         ),
      .rst_n_i    ( rst_n_i       ),
      .psel_i     ( s_gpio_psel   ),
      .penable_i  ( s_penable     ),
      .pwrite_i   ( s_pwrite      ),
      .paddr_i    ( s_paddr       ),
      .pwdata_i   ( s_pwdata      ),
      .prdata_o   ( s_gpio_prdata ),
      .pready_o   ( s_gpio_pready ),
      .gpio_in_i  ( gpio_in_i     ),
      .gpio_out_o ( gpio_out_o    ),
      .gpio_oe_o  ( gpio_oe_o     ),
      .irq_o      ( s_gpio_irq    )
   );

   apb_pwm_timer #(
      .NUM_PWM ( NUM_PWM )
   ) i_apb_pwm_timer (
      .clk_i        ( clk_i        ),
      .rst_n_i      ( rst_n_i      ),
      .psel_i       ( s_pwm_psel   ),
      .penable_i    ( s_penable    ),
      .pwrite_i     ( s_pwrite     ),
      .paddr_i      ( s_paddr      ),
      .pwdata_i     ( s_pwdata     ),
      .prdata_o     ( s_pwm_prdata ),
      .pready_o     ( s_pwm_pready ),
      .pwm_o        ( pwm_o        ),
      .period_evt_o ( s_pwm_evt    )
   );

endmodule

// File: hdl/apb_pwm_timer.sv
/*
 * PWM timer with one shared period counter and NUM_PWM duty registers.
 * The counter runs 0..period-1 while enabled and period is non zero,
 * and restarts from 0 whenever the period is written.
 * Outputs are registered; a duty at or above the period stays high.
 * period_evt_o pulses one cycle after each wrap. NUM_PWM is 1 to 8.
 */

`timescale 1ns/1ps

module apb_pwm_timer #(
   parameter int unsigned NUM_PWM = 4
) (
   input  logic                                     clk_i,
   input  logic                                     rst_n_i,
   input  logic                                     psel_i,
   input  logic                                     penable_i,
   input  logic                                     pwrite_i,
   input  logic [apb_soc_pkg::PERIPH_WIN_BITS-1:0]  paddr_i,
   input  logic [apb_soc_pkg::APB_DATA_WIDTH-1:0]   pwdata_i,
   output logic [apb_soc_pkg::APB_DATA_WIDTH-1:0]   prdata_o,
   output logic                                     pready_o,
   output logic [NUM_PWM-1:0]                       pwm_o,
   output logic                                     period_evt_o
);

   localparam int unsigned CW = periph_pkg::PWM_CNT_WIDTH;
   localparam int unsigned OW = apb_soc_pkg::PERIPH_WIN_BITS;

   logic                 wr_en;
   logic                 period_wr;
   logic                 run;
   logic                 wrap;
   logic                 en_q;
   logic [CW-1:0]        period_q;
   logic [CW-1:0]        cnt_q;
   logic [CW-1:0]        duty_q [NUM_PWM];
   logic [NUM_PWM-1:0]   pwm_q;
   logic                 evt_q;

   assign wr_en     = psel_i && penable_i && pwrite_i;
   assign pready_o  = psel_i && penable_i;
   assign period_wr = wr_en && paddr_i == periph_pkg::PWM_PERIOD_OFS;

   assign run  = en_q && (period_q != '0);
   assign wrap = run && (cnt_q == period_q - 1'b1);

   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         en_q     <= 1'b0;
         period_q <= '0;
         cnt_q    <= '0;
         pwm_q    <= '0;
         evt_q    <= 1'b0;
         for (int i = 0; i < NUM_PWM; i++)
            duty_q[i] <= '0;
      end else begin
         if (wr_en && paddr_i == periph_pkg::PWM_CTRL_OFS)
            en_q <= pwdata_i[0];
         if (period_wr)
            period_q <= pwdata_i[CW-1:0];
         for (int i = 0; i < NUM_PWM; i++) begin
            if (wr_en && paddr_i == periph_pkg::PWM_DUTY_OFS + OW'(4 * i))
               duty_q[i] <= pwdata_i[CW-1:0];
            pwm_q[i] <= run && (cnt_q < duty_q[i]);
         end
         // Counter holds at 0 when stopped
         if (!run || wrap || period_wr)
            cnt_q <= '0;
         else
            cnt_q <= cnt_q + 1'b1;
         evt_q <= wrap;
      end
   end

   always_comb begin
      prdata_o = '0;
      if (paddr_i == periph_pkg::PWM_CTRL_OFS)
         prdata_o[0] = en_q;
      else if (paddr_i == periph_pkg::PWM_PERIOD_OFS)
         prdata_o[CW-1:0] = period_q;
      for (int i = 0; i < NUM_PWM; i++) begin
         if (paddr_i == periph_pkg::PWM_DUTY_OFS + OW'(4 * i))
            prdata_o[CW-1:0] = duty_q[i];
      end
   end

   assign pwm_o        = pwm_q;
   assign period_evt_o = evt_q;

   a_cnt_in_period: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      run |-> (cnt_q < period_q));

endmodule

// File: hdl/apb_gpio.sv
/*
 * GPIO block with direction, output, interrupt mask and status registers.
 * Inputs pass a two flop synchroniser, so IN lags the pins by 2 cycles.
 * A rising edge sets the status bit whether or not it is masked; the
 * interrupt is the OR over status AND mask. A set beats a clear.
 * NUM_GPIO ranges from 1 to 32.
 */

`timescale 1ns/1ps

module apb_gpio #(
   parameter int unsigned NUM_GPIO = 16
) (
   input  logic                                     clk_i,
   input  logic                                     rst_n_i,
   input  logic                                     psel_i,
   input  logic                                     penable_i,
   input  logic                                     pwrite_i,
   input  logic [apb_soc_pkg::PERIPH_WIN_BITS-1:0]  paddr_i,
   input  logic [apb_soc_pkg::APB_DATA_WIDTH-1:0]   pwdata_i,
   output logic [apb_soc_pkg::APB_DATA_WIDTH-1:0]   prdata_o,
   output logic                                     pready_o,
   input  logic [NUM_GPIO-1:0]                      gpio_in_i,
   output logic [NUM_GPIO-1:0]                      gpio_out_o,
   output logic [NUM_GPIO-1:0]                      gpio_oe_o,
   output logic                                     irq_o
);

   logic                  wr_en;
   logic [NUM_GPIO-1:0]   dir_q;
   logic [NUM_GPIO-1:0]   out_q;
   logic [NUM_GPIO-1:0]   irq_en_q;
   logic [NUM_GPIO-1:0]   irq_sts_q;
   logic [NUM_GPIO-1:0]   sync1_q;
   logic [NUM_GPIO-1:0]   sync2_q;
   logic [NUM_GPIO-1:0]   sync3_q;
   logic [NUM_GPIO-1:0]   rise;
   logic [NUM_GPIO-1:0]   sts_clr;

   assign wr_en    = psel_i && penable_i && pwrite_i;
   assign pready_o = psel_i && penable_i;

   // Edge seen between second and third stage
   assign rise    = sync2_q & ~sync3_q;
   assign sts_clr = (wr_en && paddr_i == periph_pkg::GPIO_IRQ_STS_OFS) ?
                    pwdata_i[NUM_GPIO-1:0] : '0;

   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         dir_q     <= '0;
         out_q     <= '0;
         irq_en_q  <= '0;
         irq_sts_q <= '0;
         sync1_q   <= '0;
         sync2_q   <= '0;
         sync3_q   <= '0;
      end else begin
         sync1_q   <= gpio_in_i;
         sync2_q   <= sync1_q;
         sync3_q   <= sync2_q;
         irq_sts_q <= (irq_sts_q & ~sts_clr) | rise;
         if (wr_en && paddr_i == periph_pkg::GPIO_DIR_OFS)
            dir_q <= pwdata_i[NUM_GPIO-1:0];
         if (wr_en && paddr_i == periph_pkg::GPIO_OUT_OFS)
            out_q <= pwdata_i[NUM_GPIO-1:0];
         if (wr_en && paddr_i == periph_pkg::GPIO_IRQ_EN_OFS)
            irq_en_q <= pwdata_i[NUM_GPIO-1:0];
      end
   end

   always_comb begin
      prdata_o = '0;
      case (paddr_i)
         periph_pkg::GPIO_DIR_OFS:     prdata_o[NUM_GPIO-1:0] = dir_q;
         periph_pkg::GPIO_OUT_OFS:     prdata_o[NUM_GPIO-1:0] = out_q;
         periph_pkg::GPIO_IN_OFS:      prdata_o[NUM_GPIO-1:0] = sync2_q;
         periph_pkg::GPIO_IRQ_EN_OFS:  prdata_o[NUM_GPIO-1:0] = irq_en_q;
         periph_pkg::GPIO_IRQ_STS_OFS: prdata_o[NUM_GPIO-1:0] = irq_sts_q;
         default:                      prdata_o = '0;
      endcase
   end

   assign gpio_out_o = out_q;
   assign gpio_oe_o  = dir_q;
   assign irq_o      = |(irq_sts_q & irq_en_q);

   // Access phase must follow a setup phase
   a_access_after_setup: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      (psel_i && penable_i) |-> $past(psel_i && !penable_i));

endmodule

// File: hdl/apb_periph_bus.sv
/*
 * APB address decoder for the GPIO and PWM windows.
 * Slaves answer in the access cycle, so no wait states are inserted.
 * Addresses outside both windows get pready and pslverr with zero data.
 * Only the window offset is forwarded to the slaves.
 */

`timescale 1ns/1ps

module apb_periph_bus (
   input  logic                                       clk_i,
   input  logic                                       rst_n_i,
   input  logic [apb_soc_pkg::APB_ADDR_WIDTH-1:0]     paddr_i,
   input  logic                                       pwrite_i,
   input  logic                                       psel_i,
   input  logic                                       penable_i,
   input  logic [apb_soc_pkg::APB_DATA_WIDTH-1:0]     pwdata_i,
   output logic [apb_soc_pkg::APB_DATA_WIDTH-1:0]     prdata_o,
   output logic                                       pready_o,
   output logic                                       pslverr_o,
   output logic                                       gpio_psel_o,
   input  logic [apb_soc_pkg::APB_DATA_WIDTH-1:0]     gpio_prdata_i,
   input  logic                                       gpio_pready_i,
   output logic                                       pwm_psel_o,
   input  logic [apb_soc_pkg::APB_DATA_WIDTH-1:0]     pwm_prdata_i,
   input  logic                                       pwm_pready_i,
   output logic [apb_soc_pkg::PERIPH_WIN_BITS-1:0]    periph_paddr_o,
   output logic [apb_soc_pkg::APB_DATA_WIDTH-1:0]     periph_pwdata_o,
   output logic                                       periph_pwrite_o,
   output logic                                       periph_penable_o
);

   localparam int unsigned AW = apb_soc_pkg::APB_ADDR_WIDTH;
   localparam int unsigned WB = apb_soc_pkg::PERIPH_WIN_BITS;
   localparam int unsigned DM = apb_soc_pkg::DECODE_MSB;

   logic                                 upper_zero;
   logic [DM-WB:0]                       win;
   logic [apb_soc_pkg::NUM_PERIPH-1:0]   sel;

   assign upper_zero = (paddr_i[AW-1:DM+1] == '0);
   assign win        = paddr_i[DM:WB];

   // One select per window, index 0 is GPIO and 1 is PWM
   assign sel[0] = psel_i && upper_zero && (win == apb_soc_pkg::GPIO_BASE[DM:WB]);
   assign sel[1] = psel_i && upper_zero && (win == apb_soc_pkg::PWM_BASE[DM:WB]);

   assign gpio_psel_o = sel[0];
   assign pwm_psel_o  = sel[1];

   assign periph_paddr_o   = paddr_i[WB-1:0];
   assign periph_pwdata_o  = pwdata_i;
   assign periph_pwrite_o  = pwrite_i;
   assign periph_penable_o = penable_i;

   // Response merge
   always_comb begin
      prdata_o  = '0;
      pready_o  = 1'b0;
      pslverr_o = 1'b0;
      if (sel[0]) begin
         prdata_o = gpio_prdata_i;
         pready_o = gpio_pready_i;
      end else if (sel[1]) begin
         prdata_o = pwm_prdata_i;
         pready_o = pwm_pready_i;
      end else if (psel_i && penable_i) begin
         // Unmapped address
         pready_o  = 1'b1;
         pslverr_o = 1'b1;
      end
   end

   a_one_slave: assert property (@(posedge clk_i) disable iff (!rst_n_i) $onehot0(sel));

   // Any response, error or not, comes with pready in an access cycle
   a_err_ready: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      (pready_o || pslverr_o) |-> (pready_o && psel_i && penable_i));

endmodule

// File: hdl/periph_pkg.sv
/*
 * Register maps of the GPIO block and the PWM timer.
 * Offsets are byte offsets inside a peripheral window and are word
 * aligned. Accesses to any other offset read zero and writes are dropped.
 */

package periph_pkg;

   // GPIO registers
   // Direction, 1 means the pin drives
   localparam logic [apb_soc_pkg::PERIPH_WIN_BITS-1:0] GPIO_DIR_OFS     = 12'h000;
   localparam logic [apb_soc_pkg::PERIPH_WIN_BITS-1:0] GPIO_OUT_OFS     = 12'h004;
   // Synchronised pin value, read only
   localparam logic [apb_soc_pkg::PERIPH_WIN_BITS-1:0] GPIO_IN_OFS      = 12'h008;
   localparam logic [apb_soc_pkg::PERIPH_WIN_BITS-1:0] GPIO_IRQ_EN_OFS  = 12'h00C;
   // Rising edge status, write 1 to clear
   localparam logic [apb_soc_pkg::PERIPH_WIN_BITS-1:0] GPIO_IRQ_STS_OFS = 12'h010;

   // PWM registers
   // Bit 0 enables the timer
   localparam logic [apb_soc_pkg::PERIPH_WIN_BITS-1:0] PWM_CTRL_OFS   = 12'h000;
   localparam logic [apb_soc_pkg::PERIPH_WIN_BITS-1:0] PWM_PERIOD_OFS = 12'h004;
   // Channel n at PWM_DUTY_OFS + 4*n
   localparam logic [apb_soc_pkg::PERIPH_WIN_BITS-1:0] PWM_DUTY_OFS   = 12'h010;

   // Counter, period and duty width
   localparam int unsigned PWM_CNT_WIDTH = 16;

endpackage

// File: hdl/apb_soc_pkg.sv
/*
 * Bus widths and address map of the APB peripheral subsystem.
 * Each peripheral owns one 4 KiB window. Address bits 15..12 pick the
 * window and every bit above 15 must be zero, otherwise the access is
 * answered with an error by the peripheral bus.
 */

package apb_soc_pkg;

   // APB bus widths
   localparam int unsigned APB_ADDR_WIDTH = 32;
   localparam int unsigned APB_DATA_WIDTH = 32;

   // Number of slaves behind the peripheral bus
   localparam int unsigned NUM_PERIPH = 2;

   // Offset bits inside one window
   localparam int unsigned PERIPH_WIN_BITS = 12;

   // Highest address bit that takes part in the window decode
   localparam int unsigned DECODE_MSB = 15;

   // Window base addresses
   localparam logic [APB_ADDR_WIDTH-1:0] GPIO_BASE = 32'h0000_0000;
   localparam logic [APB_ADDR_WIDTH-1:0] PWM_BASE  = 32'h0000_1000;

endpackage
